//--- dv/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

function automatic logic [ex_pkg::XLEN-1:0] sext_word(input logic [ex_pkg::WORD_W-1:0] w);
    return {{(ex_pkg::XLEN-ex_pkg::WORD_W){w[ex_pkg::WORD_W-1]}}, w};
endfunction

// Source operand as seen by the execute stage
function automatic logic [ex_pkg::XLEN-1:0] model_operand
(
    input logic [ex_pkg::REGNO_W-1:0] regno,
    input logic [ex_pkg::XLEN-1:0] reg_value,
    input logic [ex_pkg::REGNO_W-1:0] a_rd,
    input logic a_load,
    input logic [ex_pkg::XLEN-1:0] a_res,
    input logic [ex_pkg::REGNO_W-1:0] m_rd,
    input logic m_load,
    input logic [ex_pkg::XLEN-1:0] m_data,
    input logic [ex_pkg::XLEN-1:0] m_res,
    input logic [ex_pkg::REGNO_W-1:0] w_rd,
    input logic [ex_pkg::XLEN-1:0] w_data
);
    if (regno == 0)
        return reg_value;
    if (regno == a_rd && !a_load)
        return a_res;
    if (regno == m_rd)
        return m_load ? m_data : m_res;
    if (regno == w_rd)
        return w_data;
    return reg_value;
endfunction

function automatic logic model_hazard
(
    input logic [ex_pkg::REGNO_W-1:0] ra,
    input logic [ex_pkg::REGNO_W-1:0] rb,
    input logic [ex_pkg::REGNO_W-1:0] a_rd,
    input logic a_load
);
    return a_load && a_rd != 0 && (ra == a_rd || rb == a_rd);
endfunction

function automatic logic [ex_pkg::XLEN-1:0] model_result
(
    input logic [ex_pkg::OP_W-1:0] op,
    input logic use_imm,
    input logic [ex_pkg::XLEN-1:0] a,
    input logic [ex_pkg::XLEN-1:0] b,
    input logic [ex_pkg::XLEN-1:0] imm,
    input logic [ex_pkg::XLEN-1:0] pc_next
);
    logic [ex_pkg::XLEN-1:0] bo;
    logic [ex_pkg::WORD_W-1:0] w;
    bo = use_imm ? imm : b;
    case (op)
        ex_pkg::OP_ADD: return a + bo;
        ex_pkg::OP_SUB: return a - bo;
        ex_pkg::OP_SLL: return a << bo[5:0];
        ex_pkg::OP_SLT: return ($signed(a) < $signed(bo)) ? 64'd1 : 64'd0;
        ex_pkg::OP_SLTU: return (a < bo) ? 64'd1 : 64'd0;
        ex_pkg::OP_XOR: return a ^ bo;
        ex_pkg::OP_SRL: return a >> bo[5:0];
        ex_pkg::OP_SRA: return $signed(a) >>> bo[5:0];
        ex_pkg::OP_OR: return a | bo;
        ex_pkg::OP_AND: return a & bo;
        ex_pkg::OP_ADDW: return sext_word(a[31:0] + bo[31:0]);
        ex_pkg::OP_SUBW: return sext_word(a[31:0] - bo[31:0]);
        ex_pkg::OP_SLLW: return sext_word(a[31:0] << bo[4:0]);
        ex_pkg::OP_SRLW: return sext_word(a[31:0] >> bo[4:0]);
        ex_pkg::OP_SRAW:
        begin
            w = $signed(a[31:0]) >>> bo[4:0];
            return sext_word(w);
        end
        ex_pkg::OP_LUI: return imm;
        ex_pkg::OP_AUIPC: return pc_next - 64'd4 + imm;
        ex_pkg::OP_JAL, ex_pkg::OP_JALR: return pc_next;
        ex_pkg::OP_LOAD, ex_pkg::OP_STORE: return a + imm;
        ex_pkg::OP_MUL: return a * b;
        ex_pkg::OP_MULW:
        begin
            w = a[31:0] * b[31:0];
            return sext_word(w);
        end
        default: return 64'd0;
    endcase
endfunction

function automatic logic model_taken
(
    input logic [ex_pkg::OP_W-1:0] op,
    input logic [ex_pkg::XLEN-1:0] a,
    input logic [ex_pkg::XLEN-1:0] b
);
    case (op)
        ex_pkg::OP_JAL, ex_pkg::OP_JALR: return 1'b1;
        ex_pkg::OP_BEQ: return a == b;
        ex_pkg::OP_BNE: return a != b;
        ex_pkg::OP_BLT: return $signed(a) < $signed(b);
        ex_pkg::OP_BGE: return !($signed(a) < $signed(b));
        ex_pkg::OP_BLTU: return a < b;
        ex_pkg::OP_BGEU: return !(a < b);
        default: return 1'b0;
    endcase
endfunction

function automatic logic [ex_pkg::XLEN-1:0] model_target
(
    input logic [ex_pkg::OP_W-1:0] op,
    input logic [ex_pkg::XLEN-1:0] a,
    input logic [ex_pkg::XLEN-1:0] b,
    input logic [ex_pkg::XLEN-1:0] imm,
    input logic [ex_pkg::XLEN-1:0] pc_next
);
    if (op == ex_pkg::OP_JALR)
        return (a + imm) & ~64'd1;
    if (model_taken(op, a, b))
        return pc_next - 64'd4 + imm;
    return pc_next;
endfunction

function automatic logic model_write_rd(input logic [ex_pkg::OP_W-1:0] op);
    return !(op inside {ex_pkg::OP_BEQ, ex_pkg::OP_BNE, ex_pkg::OP_BLT, ex_pkg::OP_BGE,
        ex_pkg::OP_BLTU, ex_pkg::OP_BGEU, ex_pkg::OP_LOAD, ex_pkg::OP_STORE});
endfunction

`endif

//--- dv/tb_ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;

    `include "ex_ref_model.svh"

    localparam int NUM_INSTR = 400;
    localparam int MUL_TIMEOUT = 200;
    localparam logic [31:0] SEED = 32'h3e15de09;

    logic clk;
    logic reset;
    logic valid;
    logic ready;
    logic [ex_pkg::OP_W-1:0] op;
    logic use_imm;
    logic [ex_pkg::REGNO_W-1:0] rs1_regno;
    logic [ex_pkg::REGNO_W-1:0] rs2_regno;
    logic [ex_pkg::REGNO_W-1:0] rd_regno;
    logic [ex_pkg::XLEN-1:0] rs1_value;
    logic [ex_pkg::XLEN-1:0] rs2_value;
    logic [ex_pkg::XLEN-1:0] imm;
    logic [ex_pkg::XLEN-1:0] pc_next;
    logic squash;
    logic [ex_pkg::REGNO_W-1:0] alu_rd_regno;
    logic alu_is_load;
    logic [ex_pkg::XLEN-1:0] alu_result;
    logic [ex_pkg::REGNO_W-1:0] mm_rd_regno;
    logic mm_is_load;
    logic [ex_pkg::XLEN-1:0] mm_mdata;
    logic [ex_pkg::XLEN-1:0] mm_alu_result;
    logic [ex_pkg::REGNO_W-1:0] wb_rd_regno;
    logic [ex_pkg::XLEN-1:0] wb_data;
    logic [ex_pkg::XLEN-1:0] result;
    logic [ex_pkg::XLEN-1:0] store_data;
    logic [ex_pkg::XLEN-1:0] target;
    logic [ex_pkg::REGNO_W-1:0] rd_regno_out;
    logic write_rd;
    logic is_load;
    logic taken;
    logic res_valid;

    logic [31:0] lcg_state;
    int error_count;

    ex_stage u_dut
    (
        .clk(clk), .reset(reset), .valid(valid), .ready(ready), .op(op), .use_imm(use_imm),
        .rs1_regno(rs1_regno), .rs2_regno(rs2_regno), .rd_regno(rd_regno),
        .rs1_value(rs1_value), .rs2_value(rs2_value), .imm(imm), .pc_next(pc_next),
        .squash(squash), .alu_rd_regno(alu_rd_regno), .alu_is_load(alu_is_load),
        .alu_result(alu_result), .mm_rd_regno(mm_rd_regno), .mm_is_load(mm_is_load),
        .mm_mdata(mm_mdata), .mm_alu_result(mm_alu_result), .wb_rd_regno(wb_rd_regno),
        .wb_data(wb_data), .result(result), .store_data(store_data), .target(target),
        .rd_regno_out(rd_regno_out), .write_rd(write_rd), .is_load(is_load),
        .taken(taken), .res_valid(res_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Small values now and then so branch compares hit equality
    function automatic logic [ex_pkg::XLEN-1:0] pick_value();
        logic [31:0] r;
        r = lcg_rand();
        if (r[1:0] == 2'd0)
            return {60'd0, r[7:4]};
        return {lcg_rand(), lcg_rand()};
    endfunction

    function automatic logic [ex_pkg::REGNO_W-1:0] pick_regno();
        logic [31:0] r;
        r = lcg_rand() % 6;
        return r[ex_pkg::REGNO_W-1:0];
    endfunction

    task automatic abort_run(input string why);
        error_count++;
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_xlen
    (
        input string name,
        input logic [ex_pkg::XLEN-1:0] got,
        input logic [ex_pkg::XLEN-1:0] exp
    );
        if (got !== exp)
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_regno
    (
        input string name,
        input logic [ex_pkg::REGNO_W-1:0] got,
        input logic [ex_pkg::REGNO_W-1:0] exp
    );
        if (got !== exp)
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic drive_random_instr();
        logic [31:0] r;
        logic [31:0] code;
        r = lcg_rand();
        code = lcg_rand() % 29;
        op = code[ex_pkg::OP_W-1:0];
        use_imm = r[0];
        squash = r[3:1] == 3'd0;
        rs1_regno = pick_regno();
        rs2_regno = pick_regno();
        rd_regno = pick_regno();
        rs1_value = pick_value();
        rs2_value = pick_value();
        r = lcg_rand();
        imm = {{52{r[11]}}, r[11:0]};
        pc_next = {lcg_rand(), lcg_rand()} & ~64'd3;
        r = lcg_rand();
        alu_rd_regno = pick_regno();
        alu_is_load = r[1:0] == 2'd0;
        alu_result = pick_value();
        mm_rd_regno = pick_regno();
        mm_is_load = r[2];
        mm_mdata = pick_value();
        mm_alu_result = pick_value();
        wb_rd_regno = pick_regno();
        wb_data = pick_value();
        valid = 1'b1;
    endtask

    initial
    begin
        logic exp_hazard;
        logic exp_squash;
        logic instr_is_mul;
        logic [ex_pkg::OP_W-1:0] exp_op;
        logic [ex_pkg::REGNO_W-1:0] exp_rd;
        logic [ex_pkg::XLEN-1:0] a;
        logic [ex_pkg::XLEN-1:0] b;
        logic [ex_pkg::XLEN-1:0] exp_result;
        logic [ex_pkg::XLEN-1:0] exp_target;
        int wait_count;

        lcg_state = SEED;
        error_count = 0;
        reset = 1'b1;
        valid = 1'b0;
        op = ex_pkg::OP_ADD;
        use_imm = 1'b0;
        rs1_regno = '0;
        rs2_regno = '0;
        rd_regno = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm = '0;
        pc_next = '0;
        squash = 1'b0;
        alu_rd_regno = '0;
        alu_is_load = 1'b0;
        alu_result = '0;
        mm_rd_regno = '0;
        mm_is_load = 1'b0;
        mm_mdata = '0;
        mm_alu_result = '0;
        wb_rd_regno = '0;
        wb_data = '0;

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_flag("ready", ready, 1'b1);
        check_flag("res_valid", res_valid, 1'b0);
        check_flag("taken", taken, 1'b0);
        check_flag("write_rd", write_rd, 1'b0);
        check_flag("is_load", is_load, 1'b0);
        @(negedge clk);

        for (int n = 0; n < NUM_INSTR; n++)
        begin
            drive_random_instr();
            exp_hazard = model_hazard(rs1_regno, rs2_regno, alu_rd_regno, alu_is_load);
            #1;
            check_flag("ready", ready, !exp_hazard);
            if (exp_hazard)
            begin
                @(negedge clk);
                check_flag("res_valid", res_valid, 1'b0);
                // Load moves on to memory and a bubble enters the ALU stage
                mm_rd_regno = alu_rd_regno;
                mm_is_load = 1'b1;
                mm_mdata = pick_value();
                alu_rd_regno = '0;
                alu_is_load = 1'b0;
                #1;
                check_flag("ready", ready, 1'b1);
            end

            a = model_operand(rs1_regno, rs1_value, alu_rd_regno, alu_is_load, alu_result,
                mm_rd_regno, mm_is_load, mm_mdata, mm_alu_result, wb_rd_regno, wb_data);
            b = model_operand(rs2_regno, rs2_value, alu_rd_regno, alu_is_load, alu_result,
                mm_rd_regno, mm_is_load, mm_mdata, mm_alu_result, wb_rd_regno, wb_data);
            exp_op = op;
            exp_rd = rd_regno;
            exp_squash = squash;
            exp_result = model_result(op, use_imm, a, b, imm, pc_next);
            exp_target = model_target(op, a, b, imm, pc_next);
            instr_is_mul = op == ex_pkg::OP_MUL || op == ex_pkg::OP_MULW;

            @(negedge clk);
            valid = 1'b0;
            alu_is_load = 1'b0;

            if (instr_is_mul)
            begin
                #1;
                check_flag("ready", ready, 1'b0);
                wait_count = 0;
                while (!res_valid && !ready)
                begin
                    @(negedge clk);
                    #1;
                    wait_count++;
                    if (wait_count > MUL_TIMEOUT)
                        abort_run("Timed out waiting for the multiply to complete");
                end
                check_flag("ready", ready, 1'b1);
            end

            check_flag("res_valid", res_valid, !exp_squash);
            if (exp_squash)
            begin
                check_flag("write_rd", write_rd, 1'b0);
                check_flag("is_load", is_load, 1'b0);
                check_flag("taken", taken, 1'b0);
            end
            else
            begin
                check_xlen("result", result, exp_result);
                check_xlen("store_data", store_data, b);
                check_xlen("target", target, exp_target);
                check_regno("rd_regno_out", rd_regno_out, exp_rd);
                check_flag("write_rd", write_rd, model_write_rd(exp_op));
                check_flag("is_load", is_load, exp_op == ex_pkg::OP_LOAD);
                check_flag("taken", taken, model_taken(exp_op, a, b));
            end
            if (instr_is_mul)
            begin
                @(negedge clk);
                check_flag("res_valid", res_valid, 1'b0);
            end
        end

        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/ex_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module ex_ctrl
(
    input wire clk,
    input wire reset,
    input wire valid,
    input wire [ex_pkg::OP_W-1:0] op,
    input wire hazard,
    input wire last_step,
    output logic ready,
    output logic load_wait,
    output logic mul_start,
    output logic step_en,
    output logic word_mode,
    output logic capture_alu,
    output logic capture_mul
);

    logic [ex_pkg::ST_W-1:0] state;
    logic [ex_pkg::ST_W-1:0] state_next;
    logic is_mul;
    logic accept;
    logic word_q;

    assign is_mul = op == ex_pkg::OP_MUL || op == ex_pkg::OP_MULW;

    always_comb
    begin
        case (state)
            ex_pkg::ST_RUN: ready = !hazard;
            ex_pkg::ST_LOAD_WAIT: ready = 1'b1;
            default: ready = 1'b0;
        endcase
    end

    assign accept = valid && ready;
    assign load_wait = state == ex_pkg::ST_LOAD_WAIT;
    assign mul_start = accept && is_mul;
    assign step_en = state == ex_pkg::ST_MUL_BUSY;
    // Word mode is taken from op at start, then held for the whole multiply
    assign word_mode = mul_start ? op == ex_pkg::OP_MULW : word_q;

    // Every acceptance strobes capture_alu; with capture_mul set as well
    // it only stores the multiply's side fields
    assign capture_alu = accept;
    assign capture_mul = mul_start || (step_en && last_step);

    always_comb
    begin
        state_next = state;
        case (state)
            ex_pkg::ST_RUN:
                if (valid && hazard)
                    state_next = ex_pkg::ST_LOAD_WAIT;
                else if (mul_start)
                    state_next = ex_pkg::ST_MUL_BUSY;
            ex_pkg::ST_LOAD_WAIT:
                if (mul_start)
                    state_next = ex_pkg::ST_MUL_BUSY;
                else if (accept)
                    state_next = ex_pkg::ST_RUN;
            ex_pkg::ST_MUL_BUSY:
                if (last_step)
                    state_next = ex_pkg::ST_RUN;
            default: state_next = ex_pkg::ST_RUN;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ex_pkg::ST_RUN;
            word_q <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (mul_start)
                word_q <= op == ex_pkg::OP_MULW;
        end
    end

endmodule

`default_nettype wire

//--- hw/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int XLEN = 64;
    localparam int WORD_W = 32;
    localparam int REGNO_W = 5;
    localparam int SHAMT_W = 6;
    localparam int WSHAMT_W = 5;
    localparam int OP_W = 5;

    // Multiplier step counts, one step per multiplier bit
    localparam int MUL_CNT_W = 7;
    localparam logic [MUL_CNT_W-1:0] MUL_STEPS = 7'd64;
    localparam logic [MUL_CNT_W-1:0] MULW_STEPS = 7'd32;

    localparam logic [OP_W-1:0] OP_ADD = 5'd0;
    localparam logic [OP_W-1:0] OP_SUB = 5'd1;
    localparam logic [OP_W-1:0] OP_SLL = 5'd2;
    localparam logic [OP_W-1:0] OP_SLT = 5'd3;
    localparam logic [OP_W-1:0] OP_SLTU = 5'd4;
    localparam logic [OP_W-1:0] OP_XOR = 5'd5;
    localparam logic [OP_W-1:0] OP_SRL = 5'd6;
    localparam logic [OP_W-1:0] OP_SRA = 5'd7;
    localparam logic [OP_W-1:0] OP_OR = 5'd8;
    localparam logic [OP_W-1:0] OP_AND = 5'd9;
    localparam logic [OP_W-1:0] OP_ADDW = 5'd10;
    localparam logic [OP_W-1:0] OP_SUBW = 5'd11;
    localparam logic [OP_W-1:0] OP_SLLW = 5'd12;
    localparam logic [OP_W-1:0] OP_SRLW = 5'd13;
    localparam logic [OP_W-1:0] OP_SRAW = 5'd14;
    localparam logic [OP_W-1:0] OP_LUI = 5'd15;
    localparam logic [OP_W-1:0] OP_AUIPC = 5'd16;
    localparam logic [OP_W-1:0] OP_JAL = 5'd17;
    localparam logic [OP_W-1:0] OP_JALR = 5'd18;
    localparam logic [OP_W-1:0] OP_BEQ = 5'd19;
    localparam logic [OP_W-1:0] OP_BNE = 5'd20;
    localparam logic [OP_W-1:0] OP_BLT = 5'd21;
    localparam logic [OP_W-1:0] OP_BGE = 5'd22;
    localparam logic [OP_W-1:0] OP_BLTU = 5'd23;
    localparam logic [OP_W-1:0] OP_BGEU = 5'd24;
    localparam logic [OP_W-1:0] OP_LOAD = 5'd25;
    localparam logic [OP_W-1:0] OP_STORE = 5'd26;
    localparam logic [OP_W-1:0] OP_MUL = 5'd27;
    localparam logic [OP_W-1:0] OP_MULW = 5'd28;

    // Execute control states
    localparam int ST_W = 2;
    localparam logic [ST_W-1:0] ST_RUN = 2'd0;
    localparam logic [ST_W-1:0] ST_LOAD_WAIT = 2'd1;
    localparam logic [ST_W-1:0] ST_MUL_BUSY = 2'd2;

endpackage

`default_nettype wire

//--- hw/ex_result_reg.sv
`timescale 1ns/10ps
`default_nettype none

module ex_result_reg
(
    input wire clk,
    input wire reset,
    input wire capture_alu,
    input wire capture_mul,
    input wire squash,
    input wire [ex_pkg::REGNO_W-1:0] rd_regno,
    input wire [ex_pkg::XLEN-1:0] alu_result,
    input wire [ex_pkg::XLEN-1:0] product,
    input wire [ex_pkg::XLEN-1:0] target_in,
    input wire [ex_pkg::XLEN-1:0] store_data_in,
    input wire write_rd_in,
    input wire is_load_in,
    input wire taken_in,
    output logic [ex_pkg::XLEN-1:0] result,
    output logic [ex_pkg::XLEN-1:0] store_data,
    output logic [ex_pkg::XLEN-1:0] target,
    output logic [ex_pkg::REGNO_W-1:0] rd_regno_out,
    output logic write_rd,
    output logic is_load,
    output logic taken,
    output logic res_valid
);

    logic squash_held;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            res_valid <= 1'b0;
            write_rd <= 1'b0;
            is_load <= 1'b0;
            taken <= 1'b0;
            squash_held <= 1'b0;
        end
        else if (capture_alu)
        begin
            // A multiply completes later, so no pulse at its acceptance
            res_valid <= !squash && !capture_mul;
            write_rd <= write_rd_in && !squash;
            is_load <= is_load_in && !squash;
            taken <= taken_in && !squash;
            squash_held <= squash;
        end
        else
            res_valid <= capture_mul && !squash_held;
    end

    always_ff @(posedge clk)
    begin
        if (capture_alu)
        begin
            result <= alu_result;
            store_data <= store_data_in;
            target <= target_in;
            rd_regno_out <= rd_regno;
        end
        else if (capture_mul)
            result <= product;
    end

endmodule

`default_nettype wire

//--- hw/ex_stage.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stage
(
    input wire clk,
    input wire reset,
    input wire valid,
    output logic ready,
    input wire [ex_pkg::OP_W-1:0] op,
    input wire use_imm,
    input wire [ex_pkg::REGNO_W-1:0] rs1_regno,
    input wire [ex_pkg::REGNO_W-1:0] rs2_regno,
    input wire [ex_pkg::REGNO_W-1:0] rd_regno,
    input wire [ex_pkg::XLEN-1:0] rs1_value,
    input wire [ex_pkg::XLEN-1:0] rs2_value,
    input wire [ex_pkg::XLEN-1:0] imm,
    input wire [ex_pkg::XLEN-1:0] pc_next,
    input wire squash,
    input wire [ex_pkg::REGNO_W-1:0] alu_rd_regno,
    input wire alu_is_load,
    input wire [ex_pkg::XLEN-1:0] alu_result,
    input wire [ex_pkg::REGNO_W-1:0] mm_rd_regno,
    input wire mm_is_load,
    input wire [ex_pkg::XLEN-1:0] mm_mdata,
    input wire [ex_pkg::XLEN-1:0] mm_alu_result,
    input wire [ex_pkg::REGNO_W-1:0] wb_rd_regno,
    input wire [ex_pkg::XLEN-1:0] wb_data,
    output logic [ex_pkg::XLEN-1:0] result,
    output logic [ex_pkg::XLEN-1:0] store_data,
    output logic [ex_pkg::XLEN-1:0] target,
    output logic [ex_pkg::REGNO_W-1:0] rd_regno_out,
    output logic write_rd,
    output logic is_load,
    output logic taken,
    output logic res_valid
);

    logic [ex_pkg::XLEN-1:0] src1;
    logic [ex_pkg::XLEN-1:0] src2;
    logic [ex_pkg::XLEN-1:0] ex_result;
    logic [ex_pkg::XLEN-1:0] ex_target;
    logic [ex_pkg::XLEN-1:0] product;
    logic ex_write_rd;
    logic ex_is_load;
    logic ex_taken;
    logic hazard;
    logic load_wait;
    logic mul_start;
    logic step_en;
    logic word_mode;
    logic last_step;
    logic capture_alu;
    logic capture_mul;

    operand_forward u_fwd
    (
        .rs1_regno(rs1_regno), .rs2_regno(rs2_regno),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .alu_rd_regno(alu_rd_regno), .alu_is_load(alu_is_load), .alu_result(alu_result),
        .mm_rd_regno(mm_rd_regno), .mm_is_load(mm_is_load), .mm_mdata(mm_mdata),
        .mm_alu_result(mm_alu_result), .wb_rd_regno(wb_rd_regno), .wb_data(wb_data),
        .load_wait(load_wait), .src1(src1), .src2(src2), .hazard(hazard)
    );

    int_alu u_alu
    (
        .op(op), .use_imm(use_imm), .src1(src1), .src2(src2), .imm(imm), .pc_next(pc_next),
        .alu_result(ex_result), .target(ex_target), .write_rd(ex_write_rd),
        .is_load(ex_is_load), .taken(ex_taken)
    );

    seq_mul u_mul
    (
        .clk(clk), .start(mul_start), .step_en(step_en), .word_mode(word_mode),
        .src1(src1), .src2(src2), .product(product)
    );

    mul_step_counter u_cnt
    (
        .clk(clk), .reset(reset), .start(mul_start), .word_mode(word_mode),
        .step_en(step_en), .last_step(last_step)
    );

    ex_ctrl u_ctrl
    (
        .clk(clk), .reset(reset), .valid(valid), .op(op), .hazard(hazard),
        .last_step(last_step), .ready(ready), .load_wait(load_wait), .mul_start(mul_start),
        .step_en(step_en), .word_mode(word_mode), .capture_alu(capture_alu),
        .capture_mul(capture_mul)
    );

    ex_result_reg u_res
    (
        .clk(clk), .reset(reset), .capture_alu(capture_alu), .capture_mul(capture_mul),
        .squash(squash), .rd_regno(rd_regno), .alu_result(ex_result), .product(product),
        .target_in(ex_target), .store_data_in(src2), .write_rd_in(ex_write_rd),
        .is_load_in(ex_is_load), .taken_in(ex_taken), .result(result),
        .store_data(store_data), .target(target), .rd_regno_out(rd_regno_out),
        .write_rd(write_rd), .is_load(is_load), .taken(taken), .res_valid(res_valid)
    );

endmodule

`default_nettype wire

//--- hw/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

module int_alu
(
    input wire [ex_pkg::OP_W-1:0] op,
    input wire use_imm,
    input wire [ex_pkg::XLEN-1:0] src1,
    input wire [ex_pkg::XLEN-1:0] src2,
    input wire [ex_pkg::XLEN-1:0] imm,
    input wire [ex_pkg::XLEN-1:0] pc_next,
    output logic [ex_pkg::XLEN-1:0] alu_result,
    output logic [ex_pkg::XLEN-1:0] target,
    output logic write_rd,
    output logic is_load,
    output logic taken
);

    logic [ex_pkg::XLEN-1:0] opb;
    logic [ex_pkg::XLEN-1:0] pc_rel;
    logic [ex_pkg::XLEN-1:0] jalr_sum;
    logic [ex_pkg::WORD_W-1:0] word_res;
    logic cond;

    assign opb = use_imm ? imm : src2;
    // pc_next points past this instruction
    assign pc_rel = pc_next - 4 + imm;
    assign jalr_sum = src1 + imm;

    always_comb
    begin
        case (op)
            ex_pkg::OP_ADDW: word_res = src1[ex_pkg::WORD_W-1:0] + opb[ex_pkg::WORD_W-1:0];
            ex_pkg::OP_SUBW: word_res = src1[ex_pkg::WORD_W-1:0] - opb[ex_pkg::WORD_W-1:0];
            ex_pkg::OP_SLLW: word_res = src1[ex_pkg::WORD_W-1:0] << opb[ex_pkg::WSHAMT_W-1:0];
            ex_pkg::OP_SRLW: word_res = src1[ex_pkg::WORD_W-1:0] >> opb[ex_pkg::WSHAMT_W-1:0];
            ex_pkg::OP_SRAW:
                word_res = $signed(src1[ex_pkg::WORD_W-1:0]) >>> opb[ex_pkg::WSHAMT_W-1:0];
            default: word_res = '0;
        endcase
    end

    always_comb
    begin
        case (op)
            ex_pkg::OP_ADD: alu_result = src1 + opb;
            ex_pkg::OP_SUB: alu_result = src1 - opb;
            ex_pkg::OP_SLL: alu_result = src1 << opb[ex_pkg::SHAMT_W-1:0];
            ex_pkg::OP_SLT: alu_result = {{(ex_pkg::XLEN-1){1'b0}}, $signed(src1) < $signed(opb)};
            ex_pkg::OP_SLTU: alu_result = {{(ex_pkg::XLEN-1){1'b0}}, src1 < opb};
            ex_pkg::OP_XOR: alu_result = src1 ^ opb;
            ex_pkg::OP_SRL: alu_result = src1 >> opb[ex_pkg::SHAMT_W-1:0];
            ex_pkg::OP_SRA: alu_result = $signed(src1) >>> opb[ex_pkg::SHAMT_W-1:0];
            ex_pkg::OP_OR: alu_result = src1 | opb;
            ex_pkg::OP_AND: alu_result = src1 & opb;
            ex_pkg::OP_ADDW, ex_pkg::OP_SUBW, ex_pkg::OP_SLLW, ex_pkg::OP_SRLW, ex_pkg::OP_SRAW:
                alu_result = {{(ex_pkg::XLEN-ex_pkg::WORD_W){word_res[ex_pkg::WORD_W-1]}}, word_res};
            ex_pkg::OP_LUI: alu_result = imm;
            ex_pkg::OP_AUIPC: alu_result = pc_rel;
            ex_pkg::OP_JAL, ex_pkg::OP_JALR: alu_result = pc_next;
            ex_pkg::OP_LOAD, ex_pkg::OP_STORE: alu_result = jalr_sum;
            // Branches carry no result and multiplies come from seq_mul
            default: alu_result = '0;
        endcase
    end

    always_comb
    begin
        case (op)
            ex_pkg::OP_BEQ: cond = src1 == src2;
            ex_pkg::OP_BNE: cond = src1 != src2;
            ex_pkg::OP_BLT: cond = $signed(src1) < $signed(src2);
            ex_pkg::OP_BGE: cond = $signed(src1) >= $signed(src2);
            ex_pkg::OP_BLTU: cond = src1 < src2;
            ex_pkg::OP_BGEU: cond = src1 >= src2;
            default: cond = 1'b0;
        endcase
    end

    always_comb
    begin
        write_rd = op inside {ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_SLL, ex_pkg::OP_SLT,
            ex_pkg::OP_SLTU, ex_pkg::OP_XOR, ex_pkg::OP_SRL, ex_pkg::OP_SRA, ex_pkg::OP_OR,
            ex_pkg::OP_AND, ex_pkg::OP_ADDW, ex_pkg::OP_SUBW, ex_pkg::OP_SLLW, ex_pkg::OP_SRLW,
            ex_pkg::OP_SRAW, ex_pkg::OP_LUI, ex_pkg::OP_AUIPC, ex_pkg::OP_JAL, ex_pkg::OP_JALR,
            ex_pkg::OP_MUL, ex_pkg::OP_MULW};
        is_load = op == ex_pkg::OP_LOAD;
        taken = cond || op == ex_pkg::OP_JAL || op == ex_pkg::OP_JALR;
        if (op == ex_pkg::OP_JALR)
            target = {jalr_sum[ex_pkg::XLEN-1:1], 1'b0};
        else if (taken)
            target = pc_rel;
        else
            target = pc_next;
    end

endmodule

`default_nettype wire

//--- hw/mul_step_counter.sv
`timescale 1ns/10ps
`default_nettype none

module mul_step_counter
(
    input wire clk,
    input wire reset,
    input wire start,
    input wire word_mode,
    input wire step_en,
    output logic last_step
);

    logic [ex_pkg::MUL_CNT_W-1:0] count;

    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= word_mode ? ex_pkg::MULW_STEPS : ex_pkg::MUL_STEPS;
        else if (step_en && count != '0)
            count <= count - 1'b1;
    end

    assign last_step = step_en && count == 'd1;

endmodule

`default_nettype wire

//--- hw/operand_forward.sv
`timescale 1ns/10ps
`default_nettype none

module operand_forward
(
    input wire [ex_pkg::REGNO_W-1:0] rs1_regno,
    input wire [ex_pkg::REGNO_W-1:0] rs2_regno,
    input wire [ex_pkg::XLEN-1:0] rs1_value,
    input wire [ex_pkg::XLEN-1:0] rs2_value,
    input wire [ex_pkg::REGNO_W-1:0] alu_rd_regno,
    input wire alu_is_load,
    input wire [ex_pkg::XLEN-1:0] alu_result,
    input wire [ex_pkg::REGNO_W-1:0] mm_rd_regno,
    input wire mm_is_load,
    input wire [ex_pkg::XLEN-1:0] mm_mdata,
    input wire [ex_pkg::XLEN-1:0] mm_alu_result,
    input wire [ex_pkg::REGNO_W-1:0] wb_rd_regno,
    input wire [ex_pkg::XLEN-1:0] wb_data,
    input wire load_wait,
    output logic [ex_pkg::XLEN-1:0] src1,
    output logic [ex_pkg::XLEN-1:0] src2,
    output logic hazard
);

    function automatic logic [ex_pkg::XLEN-1:0] fwd_value
    (
        input logic [ex_pkg::REGNO_W-1:0] regno,
        input logic [ex_pkg::XLEN-1:0] reg_value
    );
        logic [ex_pkg::XLEN-1:0] value;
        // x0 always reads the register file value and is never bypassed
        if (regno == '0)
            value = reg_value;
        // In the wait cycle the stalled load now sits in memory
        else if (load_wait && mm_is_load && regno == mm_rd_regno)
            value = mm_mdata;
        else if (regno == alu_rd_regno && !alu_is_load)
            value = alu_result;
        else if (regno == mm_rd_regno)
            value = mm_is_load ? mm_mdata : mm_alu_result;
        else if (regno == wb_rd_regno)
            value = wb_data;
        else
            value = reg_value;
        return value;
    endfunction

    function automatic logic load_match(input logic [ex_pkg::REGNO_W-1:0] regno);
        return regno != '0 && alu_is_load && regno == alu_rd_regno;
    endfunction

    always_comb
    begin
        src1 = fwd_value(rs1_regno, rs1_value);
        src2 = fwd_value(rs2_regno, rs2_value);
        hazard = !load_wait && (load_match(rs1_regno) || load_match(rs2_regno));
    end

endmodule

`default_nettype wire

//--- hw/seq_mul.sv
`timescale 1ns/10ps
`default_nettype none

module seq_mul
(
    input wire clk,
    input wire start,
    input wire step_en,
    input wire word_mode,
    input wire [ex_pkg::XLEN-1:0] src1,
    input wire [ex_pkg::XLEN-1:0] src2,
    output logic [ex_pkg::XLEN-1:0] product
);

    logic [ex_pkg::XLEN-1:0] mcand;
    logic [ex_pkg::XLEN-1:0] mplier;
    logic [ex_pkg::XLEN-1:0] acc;
    logic [ex_pkg::XLEN-1:0] acc_next;

    // Partial product including the step in progress
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            mcand <= word_mode ? {{(ex_pkg::XLEN-ex_pkg::WORD_W){1'b0}}, src1[ex_pkg::WORD_W-1:0]}
                               : src1;
            mplier <= word_mode ? {{(ex_pkg::XLEN-ex_pkg::WORD_W){1'b0}}, src2[ex_pkg::WORD_W-1:0]}
                                : src2;
            acc <= '0;
        end
        else if (step_en)
        begin
            acc <= acc_next;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = word_mode ?
        {{(ex_pkg::XLEN-ex_pkg::WORD_W){acc_next[ex_pkg::WORD_W-1]}}, acc_next[ex_pkg::WORD_W-1:0]}
        : acc_next;

endmodule

`default_nettype wire

//--- tb.f
+incdir+dv
hw/ex_pkg.sv
hw/operand_forward.sv
hw/int_alu.sv
hw/seq_mul.sv
hw/mul_step_counter.sv
hw/ex_ctrl.sv
hw/ex_result_reg.sv
hw/ex_stage.sv
dv/tb_ex_stage.sv
